// File: dv/aes_cases.txt
# name stall src dst nblk key0 key1 key2 key3, then nblk*4 plaintext words, then nblk*4 ciphertext
# all fields hex except the name and the stall flag (0 or 1)
single_block 0 00000100 00000200 1 2b7e1516 28aed2a6 abf71588 09cf4f3c 3243f6a8 885a308d 313198a2 e0370734 193de3be a0f4e22b 9ac68d2a e9f84808
multi_block 0 00000300 00000500 3 0f0f0f0f f0f0f0f0 12345678 89abcdef 00000000 11111111 22222222 33333333 44444444 55555555 66666666 77777777 89abcdef 01234567 deadbeef cafef00d 0f0f0f0f e1e1e1e1 3016745a ba98fedc 4b4b4b4b a5a5a5a5 7452301e fedcba98 86a4c2e0 f1d3b597 cc99e897 43553de2
back_pressure 1 00000300 00000500 3 0f0f0f0f f0f0f0f0 12345678 89abcdef 00000000 11111111 22222222 33333333 44444444 55555555 66666666 77777777 89abcdef 01234567 deadbeef cafef00d 0f0f0f0f e1e1e1e1 3016745a ba98fedc 4b4b4b4b a5a5a5a5 7452301e fedcba98 86a4c2e0 f1d3b597 cc99e897 43553de2
back_pressure_single 1 00000600 00000680 1 2b7e1516 28aed2a6 abf71588 09cf4f3c 3243f6a8 885a308d 313198a2 e0370734 193de3be a0f4e22b 9ac68d2a e9f84808

// File: filelist.f
design/aes_pkg.sv
design/aes_regfile.sv
design/aes_fsm.sv
design/block_fetch.sv
design/key_whitening_engine.sv
design/block_store.sv
design/aes_top.sv
dv/aes_sva.sv
dv/aes_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module aes_tb \
  -f filelist.f -o aes_sim || exit 1
sim_out="$(./obj_dir/aes_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "All tests passed" && exit 0 || exit 1

// File: dv/aes_tb.sv
`default_nettype none

module aes_tb;

  localparam int BLOCK_WORDS = 4;
  localparam int MAX_CASES   = 8;
  localparam int MAX_WORDS   = 64;
  localparam int MEM_WORDS   = 1024;
  localparam int CASE_CYCLES = 2000;

  logic              clk;
  logic              reset_n;
  logic [31:0]       awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;
  logic [31:0]       araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic              rvalid;
  logic              rready;
  aes_pkg::mem_req_t rd_req;
  aes_pkg::mem_rsp_t rd_rsp;
  aes_pkg::mem_req_t wr_req;
  aes_pkg::mem_rsp_t wr_rsp;
  logic              done;

  // Per case: src, dst, block count, key words 0 to 3 (same order as the register map)
  string       case_name  [MAX_CASES];
  int          case_stall [MAX_CASES];
  logic [31:0] case_cfg   [MAX_CASES][7];
  logic [31:0] plain      [MAX_CASES][MAX_WORDS];
  logic [31:0] cipher     [MAX_CASES][MAX_WORDS];
  logic [31:0] mem        [MEM_WORDS];
  int          n_cases;
  int          errors;
  int          failed;
  int          done_cnt;
  logic        stall_on;
  logic [31:0] src_lo;
  logic [31:0] src_hi;

  aes_top #(.BLOCK_WORDS(BLOCK_WORDS)) uut (
    .clk       (clk),
    .reset_n   (reset_n),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rd_req_o  (rd_req),
    .rd_rsp_i  (rd_rsp),
    .wr_req_o  (wr_req),
    .wr_rsp_i  (wr_rsp),
    .done_o    (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    if (done) begin
      done_cnt++;
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
  endfunction

  // Grant delay of 0 to 3 cycles when the case asks for stalls
  function automatic bit grant_now(inout int wait_cnt, inout bit armed);
    if (!armed) begin
      wait_cnt = stall_on ? int'($urandom % 4) : 0;
      armed    = 1'b1;
    end
    if (wait_cnt == 0) begin
      armed = 1'b0;
      return 1'b1;
    end
    wait_cnt--;
    return 1'b0;
  endfunction

  // Memory model serving the read and write ports
  initial begin : memory_model
    int          rd_wait;
    int          wr_wait;
    bit          rd_armed;
    bit          wr_armed;
    logic [31:0] rd_data;
    rd_rsp   = '0;
    wr_rsp   = '0;
    rd_wait  = 0;
    wr_wait  = 0;
    rd_armed = 1'b0;
    wr_armed = 1'b0;
    rd_data  = '0;
    forever begin
      @(posedge clk);
      #1;
      // Read data follows a read grant by one cycle
      rd_rsp.r_valid = rd_rsp.gnt;
      rd_rsp.rdata   = rd_data;
      rd_rsp.gnt     = 1'b0;
      wr_rsp.gnt     = 1'b0;
      if (rd_req.req) begin
        if (grant_now(rd_wait, rd_armed)) begin
          rd_rsp.gnt = 1'b1;
          rd_data    = mem[rd_req.addr[11:2]];
          assert (rd_req.addr >= src_lo && rd_req.addr < src_hi) else begin
            $display("read outside the source range at address %h", rd_req.addr);
            errors++;
          end
        end
      end
      if (wr_req.req && wr_req.we) begin
        if (grant_now(wr_wait, wr_armed)) begin
          wr_rsp.gnt = 1'b1;
          mem[wr_req.addr[11:2]] = wr_req.wdata;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("error %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err0);
      failed++;
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    assert (wready) else begin
      $display("write data was not accepted together with the write address");
      errors++;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    // Hold off the response for one cycle
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    // Hold off the response for one cycle
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic read_cases();
    int    fd;
    int    rc;
    int    nwords;
    string tok;
    string line;
    fd = $fopen("dv/aes_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file dv/aes_cases.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          rc = $fgets(line, fd);
        end else if (n_cases < MAX_CASES) begin
          case_name[n_cases] = tok;
          rc = $fscanf(fd, "%d", case_stall[n_cases]);
          for (int r = 0; r < 7; r++) begin
            rc = $fscanf(fd, "%h", case_cfg[n_cases][r]);
          end
          nwords = int'(case_cfg[n_cases][2]) * BLOCK_WORDS;
          for (int j = 0; j < nwords; j++) begin
            rc = $fscanf(fd, "%h", plain[n_cases][j]);
          end
          for (int j = 0; j < nwords; j++) begin
            rc = $fscanf(fd, "%h", cipher[n_cases][j]);
          end
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int c);
    int          err0;
    int          nwords;
    int          cycles;
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    logic [31:0] addr;
    logic [31:0] dst;
    err0     = errors;
    name     = case_name[c];
    nwords   = int'(case_cfg[c][2]) * BLOCK_WORDS;
    src_lo   = case_cfg[c][0];
    src_hi   = src_lo + 32'(nwords * 4);
    dst      = case_cfg[c][1];
    stall_on = (case_stall[c] != 0);
    for (int j = 0; j < MEM_WORDS; j++) begin
      mem[j] = fill_word(32'(j * 4));
    end
    for (int j = 0; j < nwords; j++) begin
      mem[(src_lo >> 2) + 32'(j)] = plain[c][j];
    end
    for (int r = 0; r < 7; r++) begin
      axi_write(aes_pkg::REG_SRC + 32'(4 * r), case_cfg[c][r]);
    end
    for (int r = 0; r < 7; r++) begin
      axi_read(aes_pkg::REG_SRC + 32'(4 * r), got);
      check_value($sformatf("%s reg %h", name, aes_pkg::REG_SRC + 32'(4 * r)),
                  case_cfg[c][r], got);
    end
    done_cnt = 0;
    axi_write(aes_pkg::REG_CTRL, 32'h1);
    axi_read(aes_pkg::REG_STATUS, got);
    check_value({name, " status while busy"}, 32'h1, got);
    // A second start during the job must be dropped
    axi_write(aes_pkg::REG_CTRL, 32'h1);
    cycles = 0;
    while (done_cnt == 0 && cycles < CASE_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    assert (done_cnt != 0) else begin
      $display("test %s: the job never signalled done", name);
      errors++;
    end
    repeat (20) @(negedge clk);
    check_value({name, " done count"}, 32'd1, 32'(done_cnt));
    axi_read(aes_pkg::REG_STATUS, got);
    check_value({name, " status after job"}, 32'h2, got);
    for (int j = 0; j < MEM_WORDS; j++) begin
      addr = 32'(j * 4);
      if (addr >= dst && addr < dst + 32'(nwords * 4)) begin
        exp = cipher[c][(addr - dst) >> 2];
      end else if (addr >= src_lo && addr < src_hi) begin
        exp = plain[c][(addr - src_lo) >> 2];
      end else begin
        exp = fill_word(addr);
      end
      check_value($sformatf("%s mem %h", name, addr), exp, mem[j]);
    end
    report_test(name, err0);
  endtask

  initial begin : main
    int          err0;
    logic [31:0] got;
    void'($urandom(14));
    reset_n  = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    stall_on = 1'b0;
    src_lo   = '0;
    src_hi   = '0;
    n_cases  = 0;
    errors   = 0;
    failed   = 0;
    done_cnt = 0;
    read_cases();
    fork
      begin
        #((n_cases + 1) * CASE_CYCLES * 8);
        $display("timeout: the run did not finish in the allowed time");
        $display("Some tests failed");
        $finish;
      end
    join_none
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    err0 = errors;
    axi_read(aes_pkg::REG_STATUS, got);
    check_value("reset_status", 32'h0, got);
    report_test("reset_status", err0);
    for (int c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    $display("%0d tests, %0d failed, %0d errors", n_cases + 1, failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/aes_sva.sv
`default_nettype none

module aes_sva (
  input wire logic                clk,
  input wire logic                reset_n,
  input wire aes_pkg::mem_req_t   rd_req_i,
  input wire aes_pkg::mem_rsp_t   rd_rsp_i,
  input wire aes_pkg::mem_req_t   wr_req_i,
  input wire aes_pkg::mem_rsp_t   wr_rsp_i,
  input wire logic                done_i,
  input wire aes_pkg::aes_state_t state_i,
  input wire logic                bvalid_i,
  input wire logic                bready_i,
  input wire logic                rvalid_i,
  input wire logic                rready_i,
  input wire logic [31:0]         rdata_i
);

  rd_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req_i.req && !rd_rsp_i.gnt |=> $stable(rd_req_i))
    else $error("read request changed before its grant");

  wr_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
    wr_req_i.req && !wr_rsp_i.gnt |=> $stable(wr_req_i))
    else $error("write request changed before its grant");

  done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else $error("done held for more than one cycle");

  bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("rvalid or rdata changed before rready");

  // Stages only request while the FSM runs a job
  idle_no_req: assert property (@(posedge clk) disable iff (!reset_n)
    state_i == aes_pkg::IDLE |-> !rd_req_i.req && !wr_req_i.req)
    else $error("memory request while the FSM is idle");

endmodule

bind aes_top aes_sva sva_i (
  .clk      (clk),
  .reset_n  (reset_n),
  .rd_req_i (rd_req_o),
  .rd_rsp_i (rd_rsp_i),
  .wr_req_i (wr_req_o),
  .wr_rsp_i (wr_rsp_i),
  .done_i   (done_o),
  .state_i  (i_fsm.state_q),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i),
  .rdata_i  (rdata_o)
);

`default_nettype wire

// File: design/aes_top.sv
`default_nettype none

module aes_top #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic              clk,
  input  wire logic              reset_n,
  // AXI4-Lite slave
  input  wire logic [31:0]       awaddr_i,
  input  wire logic              awvalid_i,
  output logic                   awready_o,
  input  wire logic [31:0]       wdata_i,
  input  wire logic              wvalid_i,
  output logic                   wready_o,
  output logic                   bvalid_o,
  input  wire logic              bready_i,
  input  wire logic [31:0]       araddr_i,
  input  wire logic              arvalid_i,
  output logic                   arready_o,
  output logic [31:0]            rdata_o,
  output logic                   rvalid_o,
  input  wire logic              rready_i,
  // Memory ports
  output aes_pkg::mem_req_t      rd_req_o,
  input  wire aes_pkg::mem_rsp_t rd_rsp_i,
  output aes_pkg::mem_req_t      wr_req_o,
  input  wire aes_pkg::mem_rsp_t wr_rsp_i,
  output logic                   done_o
);

  aes_pkg::cfg_t                cfg;
  aes_pkg::stage_ctrl_t         fetch_ctrl;
  aes_pkg::stage_ctrl_t         store_ctrl;
  aes_pkg::stage_flags_t        fetch_flags;
  aes_pkg::stage_flags_t        store_flags;
  logic                         start;
  logic                         busy;
  logic                         whiten;
  logic [BLOCK_WORDS*32-1:0]    plain_block;
  logic [BLOCK_WORDS*32-1:0]    cipher_block;

  aes_regfile i_regfile (
    .clk       (clk),
    .reset_n   (reset_n),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rdata_o   (rdata_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .busy_i    (busy),
    .done_i    (done_o),
    .cfg_o     (cfg),
    .start_o   (start)
  );

  aes_fsm #(.BLOCK_WORDS(BLOCK_WORDS)) i_fsm (
    .clk           (clk),
    .reset_n       (reset_n),
    .start_i       (start),
    .cfg_i         (cfg),
    .fetch_ctrl_o  (fetch_ctrl),
    .store_ctrl_o  (store_ctrl),
    .fetch_flags_i (fetch_flags),
    .store_flags_i (store_flags),
    .whiten_o      (whiten),
    .busy_o        (busy),
    .done_o        (done_o)
  );

  block_fetch #(.BLOCK_WORDS(BLOCK_WORDS)) i_fetch (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl_i    (fetch_ctrl),
    .flags_o   (fetch_flags),
    .mem_req_o (rd_req_o),
    .mem_rsp_i (rd_rsp_i),
    .block_o   (plain_block)
  );

  key_whitening_engine #(.BLOCK_WORDS(BLOCK_WORDS)) i_engine (
    .clk     (clk),
    .reset_n (reset_n),
    .load_i  (whiten),
    .key_i   (cfg.key),
    .block_i (plain_block),
    .block_o (cipher_block)
  );

  block_store #(.BLOCK_WORDS(BLOCK_WORDS)) i_store (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl_i    (store_ctrl),
    .flags_o   (store_flags),
    .block_i   (cipher_block),
    .mem_req_o (wr_req_o),
    .mem_rsp_i (wr_rsp_i)
  );

endmodule

`default_nettype wire

// File: design/block_store.sv
`default_nettype none

module block_store #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                     clk,
  input  wire logic                     reset_n,
  input  wire aes_pkg::stage_ctrl_t     ctrl_i,
  output aes_pkg::stage_flags_t         flags_o,
  input  wire logic [BLOCK_WORDS*32-1:0] block_i,
  output aes_pkg::mem_req_t             mem_req_o,
  input  wire aes_pkg::mem_rsp_t        mem_rsp_i
);

  localparam int IDX_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

  logic                         busy_q;
  logic                         done_q;
  logic [IDX_W-1:0]             idx_q;
  logic [31:0]                  base_q;
  logic [BLOCK_WORDS-1:0][31:0] block_q;
  logic                         last_word;

  assign last_word = idx_q == IDX_W'(BLOCK_WORDS - 1);

  // Write request stays up for the whole block, one word per grant
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (ctrl_i.start) begin
          busy_q <= 1'b1;
          idx_q  <= '0;
        end
      end else if (mem_rsp_i.gnt) begin
        if (last_word) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && ctrl_i.start) begin
      base_q  <= ctrl_i.base_addr;
      block_q <= block_i;
    end
  end

  always_comb begin
    mem_req_o.req   = busy_q;
    mem_req_o.we    = 1'b1;
    mem_req_o.addr  = base_q + (32'(idx_q) << 2);
    mem_req_o.wdata = block_q[idx_q];
  end

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;

endmodule

`default_nettype wire

// File: design/key_whitening_engine.sv
`default_nettype none

module key_whitening_engine #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                                 clk,
  input  wire logic                                 reset_n,
  input  wire logic                                 load_i,
  input  wire logic [aes_pkg::KEY_WORDS-1:0][31:0]  key_i,
  input  wire logic [BLOCK_WORDS*32-1:0]            block_i,
  output logic [BLOCK_WORDS*32-1:0]                 block_o
);

  logic [BLOCK_WORDS-1:0][31:0] words_in;
  logic [BLOCK_WORDS-1:0][31:0] words_q;

  assign words_in = block_i;
  assign block_o  = words_q;

  // AddRoundKey only; the key repeats over blocks wider than 128 bits
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      words_q <= '0;
    end else if (load_i) begin
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        words_q[i] <= words_in[i] ^ key_i[i % aes_pkg::KEY_WORDS];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/block_fetch.sv
`default_nettype none

module block_fetch #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                     clk,
  input  wire logic                     reset_n,
  input  wire aes_pkg::stage_ctrl_t     ctrl_i,
  output aes_pkg::stage_flags_t         flags_o,
  output aes_pkg::mem_req_t             mem_req_o,
  input  wire aes_pkg::mem_rsp_t        mem_rsp_i,
  output logic [BLOCK_WORDS*32-1:0]     block_o
);

  localparam int IDX_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

  logic                         busy_q;
  logic                         req_q;
  logic                         done_q;
  logic [IDX_W-1:0]             idx_q;
  logic [31:0]                  base_q;
  logic [BLOCK_WORDS-1:0][31:0] block_q;
  logic                         last_word;

  assign last_word = idx_q == IDX_W'(BLOCK_WORDS - 1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (ctrl_i.start) begin
          busy_q <= 1'b1;
          req_q  <= 1'b1;
          idx_q  <= '0;
        end
      end else begin
        if (req_q && mem_rsp_i.gnt) begin
          req_q <= 1'b0;
        end
        // Next word only after the previous one came back
        if (mem_rsp_i.r_valid) begin
          if (last_word) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end else begin
            idx_q <= idx_q + 1'b1;
            req_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && ctrl_i.start) begin
      base_q <= ctrl_i.base_addr;
    end
    if (busy_q && mem_rsp_i.r_valid) begin
      block_q[idx_q] <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.req   = req_q;
    mem_req_o.addr  = base_q + (32'(idx_q) << 2);
  end

  assign flags_o.busy = busy_q;
  assign flags_o.done = done_q;
  assign block_o      = block_q;

endmodule

`default_nettype wire

// File: design/aes_fsm.sv
`default_nettype none

module aes_fsm #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire logic                  start_i,
  input  wire aes_pkg::cfg_t         cfg_i,
  output aes_pkg::stage_ctrl_t       fetch_ctrl_o,
  output aes_pkg::stage_ctrl_t       store_ctrl_o,
  input  wire aes_pkg::stage_flags_t fetch_flags_i,
  input  wire aes_pkg::stage_flags_t store_flags_i,
  output logic                       whiten_o,
  output logic                       busy_o,
  output logic                       done_o
);

  localparam logic [31:0] BLOCK_BYTES = 32'(BLOCK_WORDS * 4);

  aes_pkg::aes_state_t state_q;
  aes_pkg::aes_state_t state_d;
  logic [31:0]         blk_cnt_q;
  logic [31:0]         blk_offset;
  logic                last_block;
  logic                fetch_start_q;
  logic                store_start_q;

  assign blk_offset = blk_cnt_q * BLOCK_BYTES;
  assign last_block = (blk_cnt_q + 32'd1) == cfg_i.num_blocks;

  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq_state
    if (!reset_n) begin
      state_q <= aes_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : fsm_comb_next_state
    state_d = state_q;
    case (state_q)
      aes_pkg::IDLE: begin
        if (start_i) begin
          state_d = aes_pkg::STARTING;
        end
      end
      // Empty job skips the pipeline
      aes_pkg::STARTING: begin
        if (cfg_i.num_blocks == 32'd0) begin
          state_d = aes_pkg::FINISHED;
        end else begin
          state_d = aes_pkg::FETCH;
        end
      end
      aes_pkg::FETCH: begin
        if (fetch_flags_i.done) begin
          state_d = aes_pkg::WHITEN;
        end
      end
      aes_pkg::WHITEN: begin
        state_d = aes_pkg::STORE;
      end
      aes_pkg::STORE: begin
        if (store_flags_i.done) begin
          state_d = last_block ? aes_pkg::FINISHED : aes_pkg::FETCH;
        end
      end
      aes_pkg::FINISHED: begin
        state_d = aes_pkg::IDLE;
      end
      default: begin
        state_d = aes_pkg::IDLE;
      end
    endcase
  end

  // Block counter, advanced once each block is stored
  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq_block_counter
    if (!reset_n) begin
      blk_cnt_q <= 32'd0;
    end else if (state_q == aes_pkg::STARTING) begin
      blk_cnt_q <= 32'd0;
    end else if (state_q == aes_pkg::STORE && store_flags_i.done) begin
      blk_cnt_q <= blk_cnt_q + 32'd1;
    end
  end

  // Stage starts pulse in the first cycle of their state
  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq_stage_start
    if (!reset_n) begin
      fetch_start_q <= 1'b0;
      store_start_q <= 1'b0;
    end else begin
      fetch_start_q <= (state_d == aes_pkg::FETCH) && (state_q != aes_pkg::FETCH);
      store_start_q <= (state_d == aes_pkg::STORE) && (state_q != aes_pkg::STORE);
    end
  end

  always_comb begin : fsm_comb_out
    fetch_ctrl_o.start     = fetch_start_q;
    fetch_ctrl_o.base_addr = cfg_i.src_addr + blk_offset;
    store_ctrl_o.start     = store_start_q;
    store_ctrl_o.base_addr = cfg_i.dst_addr + blk_offset;
    whiten_o = (state_q == aes_pkg::WHITEN);
    done_o   = (state_q == aes_pkg::FINISHED);
    busy_o   = (state_q != aes_pkg::IDLE) || fetch_flags_i.busy || store_flags_i.busy;
  end

endmodule

`default_nettype wire

// File: design/aes_regfile.sv
`default_nettype none

module aes_regfile (
  input  wire logic           clk,
  input  wire logic           reset_n,
  // AXI4-Lite slave
  input  wire logic [31:0]    awaddr_i,
  input  wire logic           awvalid_i,
  output logic                awready_o,
  input  wire logic [31:0]    wdata_i,
  input  wire logic           wvalid_i,
  output logic                wready_o,
  output logic                bvalid_o,
  input  wire logic           bready_i,
  input  wire logic [31:0]    araddr_i,
  input  wire logic           arvalid_i,
  output logic                arready_o,
  output logic [31:0]         rdata_o,
  output logic                rvalid_o,
  input  wire logic           rready_i,
  // Core side
  input  wire logic           busy_i,
  input  wire logic           done_i,
  output aes_pkg::cfg_t       cfg_o,
  output logic                start_o
);

  aes_pkg::cfg_t cfg_q;
  logic          wr_fire;
  logic          rd_fire;
  logic          done_q;
  logic [31:0]   rd_mux;

  // Write needs address and data together, one at a time until B is taken
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  assign arready_o = !rvalid_o;
  assign rd_fire   = arvalid_i && arready_o;

  assign cfg_o = cfg_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_q <= '0;
    end else if (wr_fire) begin
      case (awaddr_i)
        aes_pkg::REG_SRC:  cfg_q.src_addr   <= wdata_i;
        aes_pkg::REG_DST:  cfg_q.dst_addr   <= wdata_i;
        aes_pkg::REG_NBLK: cfg_q.num_blocks <= wdata_i;
        aes_pkg::REG_KEY0: cfg_q.key[0]     <= wdata_i;
        aes_pkg::REG_KEY1: cfg_q.key[1]     <= wdata_i;
        aes_pkg::REG_KEY2: cfg_q.key[2]     <= wdata_i;
        aes_pkg::REG_KEY3: cfg_q.key[3]     <= wdata_i;
        default: ;
      endcase
    end
  end

  // Start only from idle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_o <= 1'b0;
    end else begin
      start_o <= wr_fire && (awaddr_i == aes_pkg::REG_CTRL) && wdata_i[0] && !busy_i;
    end
  end

  // Sticky done
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done_q <= 1'b0;
    end else if (start_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bvalid_o <= 1'b0;
    end else if (wr_fire) begin
      bvalid_o <= 1'b1;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  always_comb begin
    case (araddr_i)
      aes_pkg::REG_STATUS: rd_mux = {30'd0, done_q, busy_i};
      aes_pkg::REG_SRC:    rd_mux = cfg_q.src_addr;
      aes_pkg::REG_DST:    rd_mux = cfg_q.dst_addr;
      aes_pkg::REG_NBLK:   rd_mux = cfg_q.num_blocks;
      aes_pkg::REG_KEY0:   rd_mux = cfg_q.key[0];
      aes_pkg::REG_KEY1:   rd_mux = cfg_q.key[1];
      aes_pkg::REG_KEY2:   rd_mux = cfg_q.key[2];
      aes_pkg::REG_KEY3:   rd_mux = cfg_q.key[3];
      // CTRL reads as zero, start is self clearing
      default:             rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_o <= 1'b0;
    end else if (rd_fire) begin
      rvalid_o <= 1'b1;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: design/aes_pkg.sv
`default_nettype none

package aes_pkg;

  // Register map, byte offsets from the slave base
  localparam logic [31:0] REG_CTRL   = 32'h00;
  localparam logic [31:0] REG_STATUS = 32'h04;
  localparam logic [31:0] REG_SRC    = 32'h08;
  localparam logic [31:0] REG_DST    = 32'h0C;
  localparam logic [31:0] REG_NBLK   = 32'h10;
  localparam logic [31:0] REG_KEY0   = 32'h14;
  localparam logic [31:0] REG_KEY1   = 32'h18;
  localparam logic [31:0] REG_KEY2   = 32'h1C;
  localparam logic [31:0] REG_KEY3   = 32'h20;

  // The 128-bit round key, in 32-bit words
  localparam int KEY_WORDS = 4;

  // Job configuration held by the register file
  typedef struct packed {
    logic [31:0]                src_addr;
    logic [31:0]                dst_addr;
    logic [31:0]                num_blocks;
    logic [KEY_WORDS-1:0][31:0] key;
  } cfg_t;

  // Memory port, request side
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // Memory port, answer side
  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // FSM command to a fetch or store stage
  typedef struct packed {
    logic        start;
    logic [31:0] base_addr;
  } stage_ctrl_t;

  // Stage status back to the FSM
  typedef struct packed {
    logic busy;
    logic done;
  } stage_flags_t;

  typedef enum logic [2:0] {
    IDLE,
    STARTING,
    FETCH,
    WHITEN,
    STORE,
    FINISHED
  } aes_state_t;

endpackage

`default_nettype wire
